/* project.f */
source/rf_pkg.sv
source/rf_clock_gate.sv
source/rf_latch_regfile.sv
source/rf_operand_bypass.sv
source/rf_alu.sv
source/rf_issue_stage.sv
source/rf_exec_top.sv
verif/rf_tb.sv

/* source/rf_alu.sv */
`timescale 1ns/100ps

module rf_alu
(
  input  rf_pkg::alu_op_e           op_i,
  input  logic [rf_pkg::DATA_W-1:0] opnd_a_i,
  input  logic [rf_pkg::DATA_W-1:0] opnd_b_i,
  input  logic [rf_pkg::DATA_W-1:0] opnd_c_i,
  output logic [rf_pkg::DATA_W-1:0] result_o
);

  // Low word of the product, upper half dropped
  logic [rf_pkg::DATA_W-1:0]  product;
  // Shift amount from the low bits of b
  logic [rf_pkg::SHAMT_W-1:0] shamt;

  assign product = opnd_a_i * opnd_b_i;
  assign shamt   = opnd_b_i[rf_pkg::SHAMT_W-1:0];

  // ---------------------------------------------------------------------------
  // Opcode select, all arithmetic wraps at DATA_W
  // ---------------------------------------------------------------------------

  always_comb
  begin
    unique case (op_i)
      rf_pkg::OP_ADD:
      begin
        result_o = opnd_a_i + opnd_b_i;
      end
      rf_pkg::OP_SUB:
      begin
        result_o = opnd_a_i - opnd_b_i;
      end
      rf_pkg::OP_AND:
      begin
        result_o = opnd_a_i & opnd_b_i;
      end
      rf_pkg::OP_OR:
      begin
        result_o = opnd_a_i | opnd_b_i;
      end
      rf_pkg::OP_XOR:
      begin
        result_o = opnd_a_i ^ opnd_b_i;
      end
      rf_pkg::OP_SLL:
      begin
        result_o = opnd_a_i << shamt;
      end
      rf_pkg::OP_MAC:
      begin
        // Accumulate onto the third operand
        result_o = product + opnd_c_i;
      end
      rf_pkg::OP_MOVC:
      begin
        result_o = opnd_c_i;
      end
      default:
      begin
        // Only reached with an unknown opcode
        result_o = '0;
      end
    endcase
  end

endmodule

/* source/rf_clock_gate.sv */
`timescale 1ns/100ps

module rf_clock_gate
(
  input  logic clk_i,
  input  logic en_i,
  input  logic test_en_i,
  output logic clk_o
);

  // Enable held stable over the high phase of clk_i
  logic en_q;

  // Latch transparent while the clock is low
  // Enable changes during the high phase cannot reach the output
  always_latch
  begin
    if (!clk_i)
    begin
      // Scan mode forces the gate open
      en_q <= en_i | test_en_i;
    end
  end

  assign clk_o = clk_i & en_q;

  // A gated high pulse may only end together with the input clock
  // so clk_o is never seen high during a low phase of clk_i
  a_no_glitch : assert property (@(negedge clk_o) clk_i !== 1'b0)
    else $error("rf_clock_gate: clk_o high while clk_i low");

endmodule

/* source/rf_exec_top.sv */
`timescale 1ns/100ps

module rf_exec_top
(
  input  logic              clk_int,
  input  logic              rst_n,
  input  logic              test_en_i,

  // Command port
  input  logic              cmd_valid_i,
  input  rf_pkg::exec_cmd_t cmd_i,

  // Load port, write port B of the register file
  input  logic              ld_valid_i,
  input  rf_pkg::wr_req_t   ld_i,

  // Result port
  output logic              res_valid_o,
  output rf_pkg::exec_res_t res_o
);

  // Read addresses and raw register file data
  logic [rf_pkg::ADDR_W-1:0] raddr_a;
  logic [rf_pkg::ADDR_W-1:0] raddr_b;
  logic [rf_pkg::ADDR_W-1:0] raddr_c;
  logic [rf_pkg::DATA_W-1:0] rdata_a;
  logic [rf_pkg::DATA_W-1:0] rdata_b;
  logic [rf_pkg::DATA_W-1:0] rdata_c;

  // Operands after forwarding
  logic [rf_pkg::DATA_W-1:0] opnd_a;
  logic [rf_pkg::DATA_W-1:0] opnd_b;
  logic [rf_pkg::DATA_W-1:0] opnd_c;

  // Execute stage
  rf_pkg::alu_op_e           alu_op;
  logic [rf_pkg::DATA_W-1:0] alu_a;
  logic [rf_pkg::DATA_W-1:0] alu_b;
  logic [rf_pkg::DATA_W-1:0] alu_c;
  logic [rf_pkg::DATA_W-1:0] alu_result;

  // Write back on port A
  logic                      we_a;
  rf_pkg::wr_req_t           wr_a;

  rf_issue_stage i_issue_stage
  (
    .clk_int      ( clk_int     ),
    .rst_n        ( rst_n       ),
    .cmd_valid_i  ( cmd_valid_i ),
    .cmd_i        ( cmd_i       ),
    .raddr_a_o    ( raddr_a     ),
    .raddr_b_o    ( raddr_b     ),
    .raddr_c_o    ( raddr_c     ),
    .opnd_a_i     ( opnd_a      ),
    .opnd_b_i     ( opnd_b      ),
    .opnd_c_i     ( opnd_c      ),
    .op_o         ( alu_op      ),
    .alu_a_o      ( alu_a       ),
    .alu_b_o      ( alu_b       ),
    .alu_c_o      ( alu_c       ),
    .alu_result_i ( alu_result  ),
    .we_a_o       ( we_a        ),
    .wr_a_o       ( wr_a        ),
    .res_valid_o  ( res_valid_o ),
    .res_o        ( res_o       )
  );

  // Loads bypass on port B, results on port A
  rf_operand_bypass i_bypass
  (
    .raddr_a_i ( raddr_a    ),
    .raddr_b_i ( raddr_b    ),
    .raddr_c_i ( raddr_c    ),
    .rdata_a_i ( rdata_a    ),
    .rdata_b_i ( rdata_b    ),
    .rdata_c_i ( rdata_c    ),
    .we_a_i    ( we_a       ),
    .wr_a_i    ( wr_a       ),
    .we_b_i    ( ld_valid_i ),
    .wr_b_i    ( ld_i       ),
    .opnd_a_o  ( opnd_a     ),
    .opnd_b_o  ( opnd_b     ),
    .opnd_c_o  ( opnd_c     )
  );

  rf_alu i_alu
  (
    .op_i     ( alu_op     ),
    .opnd_a_i ( alu_a      ),
    .opnd_b_i ( alu_b      ),
    .opnd_c_i ( alu_c      ),
    .result_o ( alu_result )
  );

  rf_latch_regfile i_regfile
  (
    .clk_int   ( clk_int    ),
    .rst_n     ( rst_n      ),
    .test_en_i ( test_en_i  ),
    .raddr_a_i ( raddr_a    ),
    .raddr_b_i ( raddr_b    ),
    .raddr_c_i ( raddr_c    ),
    .rdata_a_o ( rdata_a    ),
    .rdata_b_o ( rdata_b    ),
    .rdata_c_o ( rdata_c    ),
    .we_a_i    ( we_a       ),
    .wr_a_i    ( wr_a       ),
    .we_b_i    ( ld_valid_i ),
    .wr_b_i    ( ld_i       )
  );

endmodule

/* source/rf_issue_stage.sv */
`timescale 1ns/100ps

module rf_issue_stage
(
  input  logic                      clk_int,
  input  logic                      rst_n,

  // Command strobe
  input  logic                      cmd_valid_i,
  input  rf_pkg::exec_cmd_t         cmd_i,

  // Operand read, addresses out and forwarded data back
  output logic [rf_pkg::ADDR_W-1:0] raddr_a_o,
  output logic [rf_pkg::ADDR_W-1:0] raddr_b_o,
  output logic [rf_pkg::ADDR_W-1:0] raddr_c_o,
  input  logic [rf_pkg::DATA_W-1:0] opnd_a_i,
  input  logic [rf_pkg::DATA_W-1:0] opnd_b_i,
  input  logic [rf_pkg::DATA_W-1:0] opnd_c_i,

  // ALU side
  output rf_pkg::alu_op_e           op_o,
  output logic [rf_pkg::DATA_W-1:0] alu_a_o,
  output logic [rf_pkg::DATA_W-1:0] alu_b_o,
  output logic [rf_pkg::DATA_W-1:0] alu_c_o,
  input  logic [rf_pkg::DATA_W-1:0] alu_result_i,

  // Write back through port A
  output logic                      we_a_o,
  output rf_pkg::wr_req_t           wr_a_o,

  // Result strobe
  output logic                      res_valid_o,
  output rf_pkg::exec_res_t         res_o
);

  // Stage valid flag
  logic                      valid_q;
  // Registered command payload
  rf_pkg::alu_op_e           op_q;
  logic [rf_pkg::ADDR_W-1:0] rd_q;
  logic [rf_pkg::DATA_W-1:0] opnd_a_q;
  logic [rf_pkg::DATA_W-1:0] opnd_b_q;
  logic [rf_pkg::DATA_W-1:0] opnd_c_q;

  // Sources read straight from the incoming command
  assign raddr_a_o = cmd_i.rs1;
  assign raddr_b_o = cmd_i.rs2;
  assign raddr_c_o = cmd_i.rs3;

  // ---------------------------------------------------------------------------
  // Issue register
  // ---------------------------------------------------------------------------

  always_ff @(posedge clk_int or negedge rst_n)
  begin
    if (!rst_n)
    begin
      valid_q <= 1'b0;
    end
    else
    begin
      valid_q <= cmd_valid_i;
    end
  end

  // Operands already include writes landing in the command cycle
  always_ff @(posedge clk_int)
  begin
    if (cmd_valid_i)
    begin
      op_q     <= cmd_i.op;
      rd_q     <= cmd_i.rd;
      opnd_a_q <= opnd_a_i;
      opnd_b_q <= opnd_b_i;
      opnd_c_q <= opnd_c_i;
    end
  end

  // Execute cycle
  assign op_o    = op_q;
  assign alu_a_o = opnd_a_q;
  assign alu_b_o = opnd_b_q;
  assign alu_c_o = opnd_c_q;

  // Same result goes to the register file and out of the slice
  assign we_a_o      = valid_q;
  assign wr_a_o      = '{addr: rd_q, data: alu_result_i};
  assign res_valid_o = valid_q;
  assign res_o       = '{rd: rd_q, data: alu_result_i};

  // Results appear exactly one cycle after their command and keep its rd
  a_res_follows_cmd : assert property (
    @(posedge clk_int) disable iff (!rst_n)
    res_valid_o |-> $past(cmd_valid_i) && (res_o.rd == $past(cmd_i.rd))
  ) else $error("rf_issue_stage: result without a command in the previous cycle");

endmodule

/* source/rf_latch_regfile.sv */
`timescale 1ns/100ps

module rf_latch_regfile
(
  input  logic                      clk_int,
  input  logic                      rst_n,
  input  logic                      test_en_i,

  // Three combinational read ports
  input  logic [rf_pkg::ADDR_W-1:0] raddr_a_i,
  input  logic [rf_pkg::ADDR_W-1:0] raddr_b_i,
  input  logic [rf_pkg::ADDR_W-1:0] raddr_c_i,
  output logic [rf_pkg::DATA_W-1:0] rdata_a_o,
  output logic [rf_pkg::DATA_W-1:0] rdata_b_o,
  output logic [rf_pkg::DATA_W-1:0] rdata_c_o,

  // Write port A, results from the issue stage
  input  logic                      we_a_i,
  input  rf_pkg::wr_req_t           wr_a_i,

  // Write port B, external loads, wins on an address clash
  input  logic                      we_b_i,
  input  rf_pkg::wr_req_t           wr_b_i
);

  // Latch storage, word 0 tied to zero
  logic [rf_pkg::DATA_W-1:0]   mem [rf_pkg::NUM_REGS];

  // Write address decode, bit 0 does not exist
  logic [rf_pkg::NUM_REGS-1:1] waddr_onehot_a;
  logic [rf_pkg::NUM_REGS-1:1] waddr_onehot_b;
  logic [rf_pkg::NUM_REGS-1:1] waddr_onehot_a_q;
  logic [rf_pkg::NUM_REGS-1:1] waddr_onehot_b_q;

  // Per-word gated clocks
  logic [rf_pkg::NUM_REGS-1:1] mem_clocks;

  // Sampled write data
  logic [rf_pkg::DATA_W-1:0]   wdata_a_q;
  logic [rf_pkg::DATA_W-1:0]   wdata_b_q;

  // Global clock, only running in cycles with a write
  logic                        clk_gated;

  // One-hot decode of a write address, all zero when the port is idle
  function automatic logic [rf_pkg::NUM_REGS-1:1] decode_waddr(
    input logic                      we,
    input logic [rf_pkg::ADDR_W-1:0] addr
  );
    logic [rf_pkg::NUM_REGS-1:1] onehot;
    onehot = '0;
    for (int w = 1; w < rf_pkg::NUM_REGS; w++)
    begin
      onehot[w] = we && (int'(addr) == w);
    end
    return onehot;
  endfunction

  // ---------------------------------------------------------------------------
  // Read side
  // ---------------------------------------------------------------------------

  // Word 0 holds zero, so address 0 needs no special case here
  assign rdata_a_o = mem[raddr_a_i];
  assign rdata_b_o = mem[raddr_b_i];
  assign rdata_c_o = mem[raddr_c_i];

  // ---------------------------------------------------------------------------
  // Write side, sample stage
  // ---------------------------------------------------------------------------

  rf_clock_gate i_cg_global
  (
    .clk_i     ( clk_int         ),
    .en_i      ( we_a_i | we_b_i ),
    .test_en_i ( test_en_i       ),
    .clk_o     ( clk_gated       )
  );

  // Separate decoders per port
  assign waddr_onehot_a = decode_waddr(we_a_i, wr_a_i.addr);
  assign waddr_onehot_b = decode_waddr(we_b_i, wr_b_i.addr);

  // Capture write data and target words at the end of the write cycle
  always_ff @(posedge clk_gated or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wdata_a_q        <= '0;
      wdata_b_q        <= '0;
      waddr_onehot_a_q <= '0;
      waddr_onehot_b_q <= '0;
    end
    else
    begin
      if (we_a_i)
      begin
        wdata_a_q <= wr_a_i.data;
      end
      if (we_b_i)
      begin
        wdata_b_q <= wr_b_i.data;
      end
      // Target words of this write cycle, empty when only scan opened the clock
      waddr_onehot_a_q <= waddr_onehot_a;
      waddr_onehot_b_q <= waddr_onehot_b;
    end
  end

  // ---------------------------------------------------------------------------
  // Write side, per-word clock gates and latches
  // ---------------------------------------------------------------------------

  for (genvar w = 1; w < rf_pkg::NUM_REGS; w++)
  begin : g_word_cg
    rf_clock_gate i_cg_word
    (
      .clk_i     ( clk_gated                             ),
      .en_i      ( waddr_onehot_a[w] | waddr_onehot_b[w] ),
      .test_en_i ( test_en_i                             ),
      .clk_o     ( mem_clocks[w]                         )
    );
  end

  // Word latches open during the high phase of their gated clock
  // Data comes from port B when its sampled select bit is set
  // Scan mode opens every word clock, so the sampled selects qualify the write
  always_latch
  begin
    mem[0] <= '0;
    for (int k = 1; k < rf_pkg::NUM_REGS; k++)
    begin
      if (mem_clocks[k] && (waddr_onehot_a_q[k] || waddr_onehot_b_q[k]))
      begin
        mem[k] <= waddr_onehot_b_q[k] ? wdata_b_q : wdata_a_q;
      end
    end
  end

  // Each port targets at most one word per cycle
  a_onehot_waddr : assert property (
    @(posedge clk_int) disable iff (!rst_n)
    $onehot0(waddr_onehot_a) && $onehot0(waddr_onehot_b)
  ) else $error("rf_latch_regfile: write decode selects more than one word");

endmodule

/* source/rf_operand_bypass.sv */
`timescale 1ns/100ps

module rf_operand_bypass
(
  // Read addresses and stored values
  input  logic [rf_pkg::ADDR_W-1:0] raddr_a_i,
  input  logic [rf_pkg::ADDR_W-1:0] raddr_b_i,
  input  logic [rf_pkg::ADDR_W-1:0] raddr_c_i,
  input  logic [rf_pkg::DATA_W-1:0] rdata_a_i,
  input  logic [rf_pkg::DATA_W-1:0] rdata_b_i,
  input  logic [rf_pkg::DATA_W-1:0] rdata_c_i,

  // Writes presented this cycle, not yet in storage
  input  logic                      we_a_i,
  input  rf_pkg::wr_req_t           wr_a_i,
  input  logic                      we_b_i,
  input  rf_pkg::wr_req_t           wr_b_i,

  // Forwarded operands
  output logic [rf_pkg::DATA_W-1:0] opnd_a_o,
  output logic [rf_pkg::DATA_W-1:0] opnd_b_o,
  output logic [rf_pkg::DATA_W-1:0] opnd_c_o
);

  // Port B before port A before storage, matching the write priority
  function automatic logic [rf_pkg::DATA_W-1:0] forward_opnd(
    input logic [rf_pkg::ADDR_W-1:0] raddr,
    input logic [rf_pkg::DATA_W-1:0] rdata,
    input logic                      we_a,
    input rf_pkg::wr_req_t           wr_a,
    input logic                      we_b,
    input rf_pkg::wr_req_t           wr_b
  );
    logic hit_a;
    logic hit_b;
    // Register 0 never forwards
    hit_a = we_a && (wr_a.addr == raddr) && (raddr != '0);
    hit_b = we_b && (wr_b.addr == raddr) && (raddr != '0);
    if (hit_b)
    begin
      return wr_b.data;
    end
    if (hit_a)
    begin
      return wr_a.data;
    end
    return rdata;
  endfunction

  assign opnd_a_o = forward_opnd(raddr_a_i, rdata_a_i, we_a_i, wr_a_i, we_b_i, wr_b_i);
  assign opnd_b_o = forward_opnd(raddr_b_i, rdata_b_i, we_a_i, wr_a_i, we_b_i, wr_b_i);
  assign opnd_c_o = forward_opnd(raddr_c_i, rdata_c_i, we_a_i, wr_a_i, we_b_i, wr_b_i);

endmodule

/* source/rf_pkg.sv */
package rf_pkg;

  // ---------------------------------------------------------------------------
  // Widths and sizes
  // ---------------------------------------------------------------------------

  // Register address width, 32 architectural registers
  localparam int ADDR_W   = 5;
  // Data word width
  localparam int DATA_W   = 32;
  // Number of words, word 0 is hardwired to zero
  localparam int NUM_REGS = 32;
  // Shift amount taken from the low bits of operand b
  localparam int SHAMT_W  = $clog2(DATA_W);

  // ---------------------------------------------------------------------------
  // ALU opcodes
  // ---------------------------------------------------------------------------

  typedef enum logic [2:0]
  {
    OP_ADD  = 3'd0,
    OP_SUB  = 3'd1,
    OP_AND  = 3'd2,
    OP_OR   = 3'd3,
    OP_XOR  = 3'd4,
    OP_SLL  = 3'd5,
    // Multiply-accumulate, low word of a*b plus c
    OP_MAC  = 3'd6,
    // Move operand c to the destination
    OP_MOVC = 3'd7
  } alu_op_e;

  // One issued command, 23 bits
  typedef struct packed {
    alu_op_e           op;
    logic [ADDR_W-1:0] rd;
    logic [ADDR_W-1:0] rs1;
    logic [ADDR_W-1:0] rs2;
    logic [ADDR_W-1:0] rs3;
  } exec_cmd_t;

  // One write request, used on both register file write ports
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } wr_req_t;

  // One result leaving the slice
  typedef struct packed {
    logic [ADDR_W-1:0] rd;
    logic [DATA_W-1:0] data;
  } exec_res_t;

endpackage

/* verif/rf_tb.sv */
`timescale 1ns/100ps

module rf_tb;

  // Phase lengths in clock cycles
  localparam int RESET_CYC   = 8;
  localparam int IDLE_CYC    = 4;
  localparam int N_RAND      = 200;
  localparam int N_DEP       = 64;
  localparam int N_COL       = 16;
  localparam int N_TEST      = 100;
  localparam int STIM_CYCLES = RESET_CYC + 2 * rf_pkg::NUM_REGS + N_RAND + N_DEP
                               + 3 * N_COL + N_TEST + 6 * IDLE_CYC;
  localparam int TIMEOUT_CYC = STIM_CYCLES + 50;

  logic                  clk_int = 1'b0;
  logic                  rst_n;
  logic                  test_en_i;
  logic                  cmd_valid_i;
  rf_pkg::exec_cmd_t     cmd_i;
  logic                  ld_valid_i;
  rf_pkg::wr_req_t       ld_i;
  logic                  res_valid_o;
  rf_pkg::exec_res_t     res_o;

  integer                seed;
  int                    cycle_cnt      = 0;
  int                    mismatch_cnt   = 0;
  int                    strobe_err_cnt = 0;
  int                    check_cnt      = 0;

  // Reference register file and the result expected in the current cycle
  logic [rf_pkg::DATA_W-1:0] model_rf [rf_pkg::NUM_REGS];
  logic                      exp_valid = 1'b0;
  rf_pkg::exec_res_t         exp_res   = '0;

  rf_exec_top i_dut
  (
    .clk_int     ( clk_int     ),
    .rst_n       ( rst_n       ),
    .test_en_i   ( test_en_i   ),
    .cmd_valid_i ( cmd_valid_i ),
    .cmd_i       ( cmd_i       ),
    .ld_valid_i  ( ld_valid_i  ),
    .ld_i        ( ld_i        ),
    .res_valid_o ( res_valid_o ),
    .res_o       ( res_o       )
  );

  // 40 ns period
  always #20 clk_int = ~clk_int;

  // ---------------------------------------------------------------------------
  // Stimulus helpers
  // ---------------------------------------------------------------------------

  function automatic logic [rf_pkg::ADDR_W-1:0] pick_addr();
    logic [31:0] w;
    w = $random(seed);
    return w[rf_pkg::ADDR_W-1:0];
  endfunction

  function automatic logic [rf_pkg::DATA_W-1:0] random_word();
    return $random(seed);
  endfunction

  function automatic rf_pkg::alu_op_e pick_op();
    logic [31:0] w;
    w = $random(seed);
    return rf_pkg::alu_op_e'(w[2:0]);
  endfunction

  function automatic rf_pkg::exec_cmd_t make_cmd(
    input rf_pkg::alu_op_e           op,
    input logic [rf_pkg::ADDR_W-1:0] rd,
    input logic [rf_pkg::ADDR_W-1:0] rs1,
    input logic [rf_pkg::ADDR_W-1:0] rs2,
    input logic [rf_pkg::ADDR_W-1:0] rs3
  );
    rf_pkg::exec_cmd_t cmd;
    cmd.op  = op;
    cmd.rd  = rd;
    cmd.rs1 = rs1;
    cmd.rs2 = rs2;
    cmd.rs3 = rs3;
    return cmd;
  endfunction

  function automatic rf_pkg::wr_req_t load_req(
    input logic [rf_pkg::ADDR_W-1:0] addr,
    input logic [rf_pkg::DATA_W-1:0] data
  );
    rf_pkg::wr_req_t req;
    req.addr = addr;
    req.data = data;
    return req;
  endfunction

  // One clock cycle of stimulus, applied just after the rising edge
  task automatic drive_cycle(
    input logic              cmd_v,
    input rf_pkg::exec_cmd_t cmd,
    input logic              ld_v,
    input rf_pkg::wr_req_t   ld
  );
    @(posedge clk_int);
    cmd_valid_i <= cmd_v;
    cmd_i       <= cmd;
    ld_valid_i  <= ld_v;
    ld_i        <= ld;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n)
    begin
      drive_cycle(1'b0, '0, 1'b0, '0);
    end
  endtask

  // ---------------------------------------------------------------------------
  // Reference model
  // ---------------------------------------------------------------------------

  function automatic logic [rf_pkg::DATA_W-1:0] expected_alu(
    input rf_pkg::alu_op_e           op,
    input logic [rf_pkg::DATA_W-1:0] a,
    input logic [rf_pkg::DATA_W-1:0] b,
    input logic [rf_pkg::DATA_W-1:0] c
  );
    logic [rf_pkg::DATA_W-1:0] prod;
    prod = a * b;
    case (op)
      rf_pkg::OP_ADD:  return a + b;
      rf_pkg::OP_SUB:  return a - b;
      rf_pkg::OP_AND:  return a & b;
      rf_pkg::OP_OR:   return a | b;
      rf_pkg::OP_XOR:  return a ^ b;
      rf_pkg::OP_SLL:  return a << b[4:0];
      rf_pkg::OP_MAC:  return prod + c;
      default:         return c;
    endcase
  endfunction

  // Port A result of this cycle first, then the load, so the load wins
  always @(posedge clk_int)
  begin
    if (!rst_n)
    begin
      exp_valid = 1'b0;
    end
    else
    begin
      if (exp_valid)
      begin
        model_rf[exp_res.rd] = exp_res.data;
      end
      if (ld_valid_i)
      begin
        model_rf[ld_i.addr] = ld_i.data;
      end
      model_rf[0] = '0;
      // Command sees every write presented up to and including this cycle
      if (cmd_valid_i)
      begin
        exp_res.rd   = cmd_i.rd;
        exp_res.data = expected_alu(cmd_i.op, model_rf[cmd_i.rs1],
                                    model_rf[cmd_i.rs2], model_rf[cmd_i.rs3]);
      end
      exp_valid = cmd_valid_i;
    end
  end

  // ---------------------------------------------------------------------------
  // Checks, sampled mid cycle
  // ---------------------------------------------------------------------------

  task automatic check_valid(input logic expected, input logic actual);
    check_cnt++;
    if (actual !== expected)
    begin
      strobe_err_cnt++;
      if (expected)
        $display("missing result strobe on res_valid_o at cycle %0d", cycle_cnt);
      else
        $display("unexpected result strobe on res_valid_o at cycle %0d", cycle_cnt);
    end
  endtask

  task automatic check_result(input rf_pkg::exec_res_t expected, input rf_pkg::exec_res_t actual);
    if (actual !== expected)
    begin
      mismatch_cnt++;
      $display("mismatch res_o at cycle %0d: expected %h, actual %h",
               cycle_cnt, expected, actual);
    end
  endtask

  always @(negedge clk_int)
  begin
    check_valid(exp_valid, res_valid_o);
    if (exp_valid && res_valid_o === 1'b1)
    begin
      check_result(exp_res, res_o);
    end
  end

  // Watchdog
  always @(posedge clk_int)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYC)
    begin
      $display("timeout: test did not finish within %0d cycles", TIMEOUT_CYC);
      $display("Simulation failed");
      $finish;
    end
  end

  // ---------------------------------------------------------------------------
  // Test sequence
  // ---------------------------------------------------------------------------

  initial
  begin
    logic [rf_pkg::ADDR_W-1:0] r;
    logic [rf_pkg::ADDR_W-1:0] s;
    logic [rf_pkg::ADDR_W-1:0] prev_rd;
    seed        = 32'h5b128b47;
    rst_n       = 1'b0;
    test_en_i   = 1'b0;
    cmd_valid_i = 1'b0;
    cmd_i       = '0;
    ld_valid_i  = 1'b0;
    ld_i        = '0;
    for (int k = 0; k < rf_pkg::NUM_REGS; k++)
    begin
      model_rf[k] = '0;
    end
    repeat (RESET_CYC) @(posedge clk_int);
    rst_n <= 1'b1;
    idle_cycles(IDLE_CYC);

    // Fill every word, then read each back through OP_MOVC, word 0 stays zero
    for (int i = 0; i < rf_pkg::NUM_REGS; i++)
    begin
      drive_cycle(1'b0, '0, 1'b1, load_req(i, random_word()));
    end
    for (int i = 0; i < rf_pkg::NUM_REGS; i++)
    begin
      drive_cycle(1'b1, make_cmd(rf_pkg::OP_MOVC, i, pick_addr(), pick_addr(), i), 1'b0, '0);
    end
    idle_cycles(IDLE_CYC);

    // Every opcode in turn over random registers
    for (int i = 0; i < N_RAND; i++)
    begin
      drive_cycle(1'b1, make_cmd(rf_pkg::alu_op_e'(i % 8), pick_addr(), pick_addr(),
                                 pick_addr(), pick_addr()), 1'b0, '0);
    end
    idle_cycles(IDLE_CYC);

    // Chain of dependent commands, port A forwarding every cycle
    prev_rd = 5'd1;
    for (int i = 0; i < N_DEP; i++)
    begin
      r = pick_addr() | 5'd1;
      drive_cycle(1'b1, make_cmd(pick_op(), r, prev_rd, pick_addr(), prev_rd), 1'b0, '0);
      prev_rd = r;
    end
    idle_cycles(IDLE_CYC);

    // Result and load collide on r, then r is read back from storage
    for (int i = 0; i < N_COL; i++)
    begin
      r = pick_addr() | 5'd1;
      s = pick_addr() | 5'd1;
      if (s == r)
        s = r ^ 5'h02;
      drive_cycle(1'b1, make_cmd(pick_op(), r, pick_addr(), pick_addr(), pick_addr()),
                  1'b0, '0);
      drive_cycle(1'b1, make_cmd(pick_op(), r ^ 5'h10, r, pick_addr(), r),
                  1'b1, load_req(r, random_word()));
      // Source s is loaded in the same cycle as the command reading it
      // Source r comes back from storage
      drive_cycle(1'b1, make_cmd(rf_pkg::OP_XOR, 5'd0, s, r, pick_addr()),
                  1'b1, load_req(s, random_word()));
    end
    idle_cycles(IDLE_CYC);

    // Scan mode, all clock gates forced open
    test_en_i <= 1'b1;
    for (int i = 0; i < N_TEST; i++)
    begin
      drive_cycle(random_word() % 2 == 1,
                  make_cmd(pick_op(), pick_addr(), pick_addr(), pick_addr(), pick_addr()),
                  random_word() % 2 == 1, load_req(pick_addr(), random_word()));
    end
    idle_cycles(IDLE_CYC);
    test_en_i <= 1'b0;

    $display("errors: %0d mismatches, %0d strobe errors, %0d cycles checked",
             mismatch_cnt, strobe_err_cnt, check_cnt);
    if (mismatch_cnt == 0 && strobe_err_cnt == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule
